// File: build.f
snake_pkg.sv
snake_ifs.sv
ps2_key_decoder.sv
game_ctrl.sv
snake_engine.sv
apb_status.sv
snake_top.sv
tb_snake.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_snake
FILELIST   := build.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJDIR     := obj_dir
LOG        := sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb_snake.sv
// Testbench for the Snake game logic, driving PS/2 keys and reading the APB status port
`timescale 1ns/100ps

module tb_snake;

	localparam int ROWS         = 9;
	localparam int PS2_HALF     = 8;
	// Short idle after a frame, so the first step comes after the next read
	localparam int PS2_GAP      = 4;
	localparam int PREADY_WAITS = 16;
	localparam int HEAD_POLLS   = 100;
	localparam int STATE_POLLS  = 500;

	logic        clk;
	logic        arst_n;
	logic        ps2_clk;
	logic        ps2_dat;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// One stimulus row
	// A value of -1 marks speed, x or y as unchecked
	// Scan codes go out low byte first
	// Apple 1 checks the start cell and 2 checks that it moved off it
	typedef struct {
		int                     keys;
		int                     nkeys;
		int                     steps;
		int                     dx;
		int                     dy;
		snake_pkg::game_state_t state;
		int                     speed;
		int                     length;
		int                     score;
		int                     hiscore;
		int                     x;
		int                     y;
		int                     apple;
	} row_t;

	row_t  rows [ROWS];
	string row_name [ROWS];
	int    checks;
	int    errors;

	snake_top snake_top_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #20 clk = ~clk;

	// ############################################################
	// Stimulus table
	// ############################################################
	task automatic load_table();
		row_name[0] = "reset";
		rows[0] = '{0, 0, 0, 0, 0, snake_pkg::MENU, -1, 0, 0, 0, -1, -1, 0};
		row_name[1] = "release key 2";
		rows[1] = '{'h1EF01E, 3, 0, 0, 0, snake_pkg::GAME_WAIT, int'(snake_pkg::SPEED_2),
			1, 0, 0, int'(snake_pkg::HEAD_X0), int'(snake_pkg::HEAD_Y0), 1};
		row_name[2] = "right, eat apple";
		rows[2] = '{'h74E0, 2, 3, 1, 0, snake_pkg::PLAYING, int'(snake_pkg::SPEED_2),
			2, 1, 1, int'(snake_pkg::HEAD_X0) + 3, int'(snake_pkg::HEAD_Y0), 2};
		row_name[3] = "left ignored";
		rows[3] = '{'h6B, 1, 2, 1, 0, snake_pkg::PLAYING, int'(snake_pkg::SPEED_2),
			2, 1, 1, -1, -1, 0};
		row_name[4] = "turn up";
		rows[4] = '{'h75, 1, 2, 0, -1, snake_pkg::PLAYING, int'(snake_pkg::SPEED_2),
			2, 1, 1, -1, -1, 0};
		row_name[5] = "wall at row 0";
		rows[5] = '{0, 0, 0, 0, 0, snake_pkg::GAME_OVER, int'(snake_pkg::SPEED_2),
			2, 1, 1, -1, 0, 0};
		row_name[6] = "release key 1";
		rows[6] = '{'h16F016, 3, 0, 0, 0, snake_pkg::MENU, int'(snake_pkg::SPEED_2),
			2, 1, 1, -1, 0, 0};
		row_name[7] = "release key 3";
		rows[7] = '{'h26F026, 3, 0, 0, 0, snake_pkg::GAME_WAIT, int'(snake_pkg::SPEED_3),
			1, 0, 1, int'(snake_pkg::HEAD_X0), int'(snake_pkg::HEAD_Y0), 1};
		row_name[8] = "right at speed 3";
		rows[8] = '{'h74E0, 2, 1, 1, 0, snake_pkg::PLAYING, int'(snake_pkg::SPEED_3),
			1, 0, 1, int'(snake_pkg::HEAD_X0) + 1, int'(snake_pkg::HEAD_Y0), 0};
	endtask

	// ############################################################
	// Compare tasks
	// ############################################################
	task automatic state_cmp(input string name, input snake_pkg::game_state_t got,
			input snake_pkg::game_state_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic speed_cmp(input string name, input snake_pkg::speed_t got,
			input snake_pkg::speed_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic coord_cmp(input string name, input snake_pkg::coord_t got,
			input snake_pkg::coord_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic len_cmp(input string name, input snake_pkg::len_t got,
			input snake_pkg::len_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic score_cmp(input string name, input snake_pkg::score_t got,
			input snake_pkg::score_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic pslverr_cmp(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// ############################################################
	// Bus and key drivers
	// ############################################################
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic timeout_abort(input string what);
		$display("timeout while waiting for %s", what);
		$display("checks %0d, errors %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	endtask

	// Start bit, eight data bits LSB first, odd parity, stop bit
	task automatic ps2_send(input logic [7:0] code);
		logic [10:0] frame;
		frame = {1'b1, ~^code, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_dat = frame[i];
			repeat (PS2_HALF) next_cycle();
			ps2_clk = 1'b0;
			repeat (PS2_HALF) next_cycle();
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1;
		repeat (PS2_GAP) next_cycle();
	endtask

	task automatic apb_access(input logic [3:0] addr, input logic write,
			output logic [31:0] data, output logic err);
		int waits;
		waits   = 0;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		next_cycle();
		penable = 1'b1;
		next_cycle();
		while (!pready) begin
			if (waits == PREADY_WAITS)
				timeout_abort("pready");
			next_cycle();
			waits++;
		end
		data    = prdata;
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		apb_access(addr, 1'b0, data, err);
		pslverr_cmp("pslverr", err, 1'b0);
	endtask

	// Poll the head register until the snake has moved
	task automatic wait_head_step(input snake_pkg::coord_t old_x, input snake_pkg::coord_t old_y,
			output snake_pkg::coord_t nx, output snake_pkg::coord_t ny);
		logic [31:0] word;
		int          polls;
		polls = 0;
		nx    = old_x;
		ny    = old_y;
		while (nx == old_x && ny == old_y) begin
			if (polls == HEAD_POLLS)
				timeout_abort("a head step");
			read_reg(snake_pkg::REG_HEAD, word);
			nx = word[5:0];
			ny = word[13:8];
			polls++;
		end
	endtask

	// Poll the status register until the state leaves the one it had before the row
	task automatic wait_state_change(input snake_pkg::game_state_t old,
			output logic [31:0] word);
		int polls;
		polls = 0;
		read_reg(snake_pkg::REG_STATUS, word);
		while (snake_pkg::game_state_t'(word[2:0]) == old) begin
			if (polls == STATE_POLLS)
				timeout_abort("a state change");
			read_reg(snake_pkg::REG_STATUS, word);
			polls++;
		end
	endtask

	task automatic report_line(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: pass", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	// ############################################################
	// Tests
	// ############################################################
	task automatic bad_access_test();
		logic [31:0] data;
		logic        err;
		int          errors_before;
		errors_before = errors;
		apb_access(snake_pkg::REG_STATUS, 1'b1, data, err);
		pslverr_cmp("pslverr", err, 1'b1);
		apb_access(4'h2, 1'b0, data, err);
		pslverr_cmp("pslverr", err, 1'b1);
		report_line("write and unknown address", errors_before);
	endtask

	task automatic run_row(input int idx);
		row_t                   row;
		logic [31:0]            word;
		snake_pkg::game_state_t old_state;
		snake_pkg::coord_t      cur_x;
		snake_pkg::coord_t      cur_y;
		snake_pkg::coord_t      new_x;
		snake_pkg::coord_t      new_y;
		int                     errors_before;
		row           = rows[idx];
		errors_before = errors;
		read_reg(snake_pkg::REG_STATUS, word);
		old_state = snake_pkg::game_state_t'(word[2:0]);
		for (int k = 0; k < row.nkeys; k++)
			ps2_send(8'(row.keys >> (8 * k)));
		// Each step moves the head by one cell in the expected direction
		if (row.steps > 0) begin
			read_reg(snake_pkg::REG_HEAD, word);
			cur_x = word[5:0];
			cur_y = word[13:8];
			for (int s = 0; s < row.steps; s++) begin
				wait_head_step(cur_x, cur_y, new_x, new_y);
				coord_cmp("head_x", new_x, snake_pkg::coord_t'(int'(cur_x) + row.dx));
				coord_cmp("head_y", new_y, snake_pkg::coord_t'(int'(cur_y) + row.dy));
				cur_x = new_x;
				cur_y = new_y;
			end
		end
		// A row that expects a new state waits for the old one to end
		if (row.state != old_state)
			wait_state_change(old_state, word);
		else
			read_reg(snake_pkg::REG_STATUS, word);
		state_cmp("state", snake_pkg::game_state_t'(word[2:0]), row.state);
		if (row.speed >= 0)
			speed_cmp("speed", word[6:4], snake_pkg::speed_t'(row.speed));
		len_cmp("length", word[12:8], snake_pkg::len_t'(row.length));
		read_reg(snake_pkg::REG_SCORE, word);
		score_cmp("score", word[12:0], snake_pkg::score_t'(row.score));
		score_cmp("hiscore", word[28:16], snake_pkg::score_t'(row.hiscore));
		if (row.steps == 0) begin
			read_reg(snake_pkg::REG_HEAD, word);
			cur_x = word[5:0];
			cur_y = word[13:8];
		end
		if (row.x >= 0)
			coord_cmp("head_x", cur_x, snake_pkg::coord_t'(row.x));
		if (row.y >= 0)
			coord_cmp("head_y", cur_y, snake_pkg::coord_t'(row.y));
		if (row.apple == 1) begin
			read_reg(snake_pkg::REG_APPLE, word);
			coord_cmp("apple_x", word[5:0], snake_pkg::APPLE_X0);
			coord_cmp("apple_y", word[13:8], snake_pkg::APPLE_Y0);
		end else if (row.apple == 2) begin
			read_reg(snake_pkg::REG_APPLE, word);
			checks++;
			if (word[5:0] == snake_pkg::APPLE_X0 && word[13:8] == snake_pkg::APPLE_Y0) begin
				$display("apple was eaten but stayed on its start cell");
				errors++;
			end
			checks++;
			if (word[5:0] < 6'd1 || int'(word[5:0]) > snake_pkg::GRID_W - 2
					|| word[13:8] < 6'd1 || int'(word[13:8]) > snake_pkg::GRID_H - 2) begin
				$display("apple moved outside the playfield interior");
				errors++;
			end
		end
		report_line($sformatf("row %0d %s", idx, row_name[idx]), errors_before);
	endtask

	initial begin
		clk     = 1'b0;
		arst_n  = 1'b0;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		checks  = 0;
		errors  = 0;
		load_table();
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		next_cycle();
		bad_access_test();
		for (int r = 0; r < ROWS; r++)
			run_row(r);
		$display("tests %0d, checks %0d, errors %0d", ROWS + 1, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: snake_top.sv
// Snake game logic top level with PS/2 input and APB status port
`timescale 1ns/100ps

module snake_top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ps2_clk,
	input  logic        ps2_dat,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	key_if  keys ();
	step_if ctl ();

	snake_pkg::game_state_t state;
	snake_pkg::speed_t      speed;
	snake_pkg::coord_t      head_x;
	snake_pkg::coord_t      head_y;
	snake_pkg::coord_t      apple_x;
	snake_pkg::coord_t      apple_y;
	snake_pkg::len_t        length;
	snake_pkg::score_t      score;
	snake_pkg::score_t      hiscore;

	ps2_key_decoder ps2_key_decoder_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.keys    (keys.source)
	);

	game_ctrl game_ctrl_i (
		.clk    (clk),
		.arst_n (arst_n),
		.keys   (keys.sink),
		.ctl    (ctl.source),
		.state  (state),
		.speed  (speed)
	);

	snake_engine snake_engine_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.keys    (keys.sink),
		.ctl     (ctl.sink),
		.head_x  (head_x),
		.head_y  (head_y),
		.apple_x (apple_x),
		.apple_y (apple_y),
		.length  (length),
		.score   (score),
		.hiscore (hiscore)
	);

	apb_status apb_status_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.state   (state),
		.speed   (speed),
		.length  (length),
		.score   (score),
		.hiscore (hiscore),
		.head_x  (head_x),
		.head_y  (head_y),
		.apple_x (apple_x),
		.apple_y (apple_y)
	);

endmodule

// File: apb_status.sv
// Read-only APB port for game status, score, head and apple registers
`timescale 1ns/100ps

module apb_status (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [3:0]             paddr,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  snake_pkg::game_state_t state,
	input  snake_pkg::speed_t      speed,
	input  snake_pkg::len_t        length,
	input  snake_pkg::score_t      score,
	input  snake_pkg::score_t      hiscore,
	input  snake_pkg::coord_t      head_x,
	input  snake_pkg::coord_t      head_y,
	input  snake_pkg::coord_t      apple_x,
	input  snake_pkg::coord_t      apple_y
);

	logic        setup;
	logic [31:0] rd_word;
	logic        rd_err;

	assign setup  = psel & ~penable;
	assign pready = 1'b1;

	always_comb begin
		rd_err = pwrite;
		case (paddr)
			snake_pkg::REG_STATUS: rd_word = {19'd0, length, 1'b0, speed, 1'b0, state};
			snake_pkg::REG_SCORE:  rd_word = {3'd0, hiscore, 3'd0, score};
			snake_pkg::REG_HEAD:   rd_word = {18'd0, head_y, 2'd0, head_x};
			snake_pkg::REG_APPLE:  rd_word = {18'd0, apple_y, 2'd0, apple_x};
			default: begin
				rd_word = '0;
				rd_err  = 1'b1;
			end
		endcase
	end

	// Read data captured in setup, held through the access phase
	always_ff @(posedge clk) begin
		if (setup)
			prdata <= rd_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pslverr <= 1'b0;
		else if (setup)
			pslverr <= rd_err;
		else if (!psel)
			pslverr <= 1'b0;
	end

	a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
		penable |-> psel)
		else $error("APB penable without psel");

	a_setup_access: assert property (@(posedge clk) disable iff (!arst_n)
		setup |=> psel && penable)
		else $error("APB setup not followed by access");

endmodule

// File: snake_engine.sv
// Snake body, movement, collision, apple and score keeping on the grid
`timescale 1ns/100ps

module snake_engine (
	input  logic              clk,
	input  logic              arst_n,
	key_if.sink               keys,
	step_if.sink              ctl,
	output snake_pkg::coord_t head_x,
	output snake_pkg::coord_t head_y,
	output snake_pkg::coord_t apple_x,
	output snake_pkg::coord_t apple_y,
	output snake_pkg::len_t   length,
	output snake_pkg::score_t score,
	output snake_pkg::score_t hiscore
);

	snake_pkg::coord_t body_x [1:snake_pkg::MAX_LEN-1];
	snake_pkg::coord_t body_y [1:snake_pkg::MAX_LEN-1];
	snake_pkg::dir_t   heading;
	snake_pkg::dir_t   last_dir;
	logic              moved;
	snake_pkg::coord_t next_x;
	snake_pkg::coord_t next_y;
	snake_pkg::coord_t scan_x;
	snake_pkg::coord_t scan_y;
	snake_pkg::score_t next_score;
	logic              wall_hit;
	logic              self_hit;
	logic              fatal;
	logic              eat;

	// ############################################################
	// Next head cell and collisions
	// ############################################################
	always_comb begin
		next_x = head_x;
		next_y = head_y;
		case (heading)
			snake_pkg::DIR_UP:   next_y = head_y - 1'b1;
			snake_pkg::DIR_LEFT: next_x = head_x - 1'b1;
			snake_pkg::DIR_DOWN: next_y = head_y + 1'b1;
			default:             next_x = head_x + 1'b1;
		endcase
	end

	assign wall_hit = (next_x == '0) || (next_y == '0)
		|| (next_x == snake_pkg::coord_t'(snake_pkg::GRID_W - 1))
		|| (next_y == snake_pkg::coord_t'(snake_pkg::GRID_H - 1));

	// Old segment j becomes j+1 after the shift; the old tail moves away
	always_comb begin
		self_hit = 1'b0;
		for (int j = snake_pkg::SELF_HIT_MIN - 1; j < snake_pkg::MAX_LEN - 1; j++) begin
			if (j + 1 < int'(length) && body_x[j] == next_x && body_y[j] == next_y)
				self_hit = 1'b1;
		end
	end

	assign fatal      = wall_hit | self_hit;
	assign eat        = !fatal && (next_x == apple_x) && (next_y == apple_y);
	assign next_score = score + 1'b1;

	// Body memory, shifted behind the head
	always_ff @(posedge clk) begin
		if (ctl.step) begin
			body_x[1] <= head_x;
			body_y[1] <= head_y;
			for (int i = 2; i < snake_pkg::MAX_LEN; i++) begin
				body_x[i] <= body_x[i-1];
				body_y[i] <= body_y[i-1];
			end
		end
	end

	// Interior scan used as the next apple position
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_x <= 6'd1;
			scan_y <= 6'd1;
		end else if (scan_x == snake_pkg::coord_t'(snake_pkg::GRID_W - 2)) begin
			scan_x <= 6'd1;
			if (scan_y == snake_pkg::coord_t'(snake_pkg::GRID_H - 2))
				scan_y <= 6'd1;
			else
				scan_y <= scan_y + 1'b1;
		end else begin
			scan_x <= scan_x + 1'b1;
		end
	end

	// ############################################################
	// Game registers
	// ############################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head_x        <= '0;
			head_y        <= '0;
			apple_x       <= '0;
			apple_y       <= '0;
			length        <= '0;
			score         <= '0;
			hiscore       <= '0;
			heading       <= snake_pkg::DIR_RIGHT;
			last_dir      <= snake_pkg::DIR_RIGHT;
			moved         <= 1'b0;
			ctl.game_over <= 1'b0;
		end else if (ctl.init) begin
			head_x        <= snake_pkg::HEAD_X0;
			head_y        <= snake_pkg::HEAD_Y0;
			apple_x       <= snake_pkg::APPLE_X0;
			apple_y       <= snake_pkg::APPLE_Y0;
			length        <= 5'd1;
			score         <= '0;
			moved         <= 1'b0;
			ctl.game_over <= 1'b0;
		end else begin
			// No turning back onto the last move
			if (ctl.running && keys.dir_valid && (!moved || keys.dir != (last_dir ^ 2'b10)))
				heading <= keys.dir;
			if (ctl.step) begin
				head_x        <= next_x;
				head_y        <= next_y;
				last_dir      <= heading;
				moved         <= 1'b1;
				ctl.game_over <= fatal;
				if (eat) begin
					if (length < snake_pkg::len_t'(snake_pkg::MAX_LEN))
						length <= length + 1'b1;
					score   <= next_score;
					apple_x <= scan_x;
					apple_y <= scan_y;
					if (next_score > hiscore)
						hiscore <= next_score;
				end
			end
		end
	end

	a_len_max: assert property (@(posedge clk) disable iff (!arst_n)
		length <= snake_pkg::len_t'(snake_pkg::MAX_LEN))
		else $error("Snake length above maximum");

endmodule

// File: game_ctrl.sv
// Game state machine with speed selection and the step timer
`timescale 1ns/100ps

module game_ctrl (
	input  logic                   clk,
	input  logic                   arst_n,
	key_if.sink                    keys,
	step_if.source                 ctl,
	output snake_pkg::game_state_t state,
	output snake_pkg::speed_t      speed
);

	snake_pkg::game_state_t next_state;
	snake_pkg::step_cnt_t   step_cnt;
	snake_pkg::step_cnt_t   period;

	// ############################################################
	// State machine
	// ############################################################
	always_comb begin
		next_state = state;
		case (state)
			snake_pkg::MENU:      if (keys.level_valid) next_state = snake_pkg::GAME_INIT;
			snake_pkg::GAME_INIT: next_state = snake_pkg::GAME_WAIT;
			snake_pkg::GAME_WAIT: if (keys.dir_valid) next_state = snake_pkg::PLAYING;
			snake_pkg::PLAYING:   if (ctl.game_over) next_state = snake_pkg::GAME_OVER;
			snake_pkg::GAME_OVER: if (keys.level_valid) next_state = snake_pkg::MENU;
			default:              next_state = snake_pkg::MENU;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= snake_pkg::MENU;
			speed <= snake_pkg::SPEED_1;
		end else begin
			state <= next_state;
			// Speed only taken from the key that starts a game
			if (state == snake_pkg::MENU && keys.level_valid)
				speed <= keys.speed;
		end
	end

	// ############################################################
	// Step timer
	// ############################################################
	assign period = snake_pkg::step_cnt_t'(speed * snake_pkg::STEP_CYCLES);

	// Full period before the first step, then one step every period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_cnt <= '0;
		end else if (state != snake_pkg::PLAYING) begin
			step_cnt <= period;
		end else if (step_cnt == '0) begin
			step_cnt <= period - 1'b1;
		end else begin
			step_cnt <= step_cnt - 1'b1;
		end
	end

	assign ctl.init    = (state == snake_pkg::GAME_INIT);
	assign ctl.running = (state == snake_pkg::GAME_WAIT) || (state == snake_pkg::PLAYING);
	assign ctl.step    = (state == snake_pkg::PLAYING) && (step_cnt == '0);

	// A step never reaches the engine once it has flagged game over
	a_step_in_play: assert property (@(posedge clk) disable iff (!arst_n)
		ctl.step |-> (state == snake_pkg::PLAYING) && !ctl.game_over)
		else $error("Step outside of play");

endmodule

// File: ps2_key_decoder.sv
// PS/2 frame receiver that turns arrow make codes and level release codes into key pulses
`timescale 1ns/100ps

module ps2_key_decoder (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  ps2_clk,
	input  logic  ps2_dat,
	key_if.source keys
);

	logic [2:0] clk_sync;
	logic [1:0] dat_sync;
	logic       clk_fall;
	logic [3:0] bit_cnt;
	logic [9:0] frame;
	logic       code_valid;
	logic [7:0] code;
	logic       brk;

	// ############################################################
	// Synchroniser and frame assembly
	// ############################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync <= 3'b111;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
		end
	end

	assign clk_fall = clk_sync[2] & ~clk_sync[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt    <= '0;
			frame      <= '0;
			code       <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					// Start low, stop high, odd parity over data and parity bit
					code       <= frame[8:1];
					code_valid <= ~frame[0] & dat_sync[1] & (^frame[9:1]);
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					frame   <= {dat_sync[1], frame[9:1]};
				end
			end
		end
	end

	// ############################################################
	// Key decoding
	// ############################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			brk              <= 1'b0;
			keys.dir_valid   <= 1'b0;
			keys.dir         <= snake_pkg::DIR_UP;
			keys.level_valid <= 1'b0;
			keys.speed       <= snake_pkg::SPEED_1;
		end else begin
			keys.dir_valid   <= 1'b0;
			keys.level_valid <= 1'b0;
			if (code_valid) begin
				if (code == snake_pkg::KEY_BREAK) begin
					brk <= 1'b1;
				end else begin
					brk <= 1'b0;
					// Level keys count on release, arrows on make
					if (brk) begin
						case (code)
							snake_pkg::KEY_1: begin
								keys.level_valid <= 1'b1;
								keys.speed       <= snake_pkg::SPEED_1;
							end
							snake_pkg::KEY_2: begin
								keys.level_valid <= 1'b1;
								keys.speed       <= snake_pkg::SPEED_2;
							end
							snake_pkg::KEY_3: begin
								keys.level_valid <= 1'b1;
								keys.speed       <= snake_pkg::SPEED_3;
							end
							default: ;
						endcase
					end else begin
						keys.dir_valid <= (code == snake_pkg::KEY_UP) || (code == snake_pkg::KEY_LEFT)
							|| (code == snake_pkg::KEY_DOWN) || (code == snake_pkg::KEY_RIGHT);
						case (code)
							snake_pkg::KEY_UP:   keys.dir <= snake_pkg::DIR_UP;
							snake_pkg::KEY_LEFT: keys.dir <= snake_pkg::DIR_LEFT;
							snake_pkg::KEY_DOWN: keys.dir <= snake_pkg::DIR_DOWN;
							default:             keys.dir <= snake_pkg::DIR_RIGHT;
						endcase
					end
				end
			end
		end
	end

	a_bit_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
		bit_cnt <= 4'd10)
		else $error("PS/2 bit counter out of range");

endmodule

// File: snake_ifs.sv
// Interfaces for decoded keys and for step control between the game blocks
`timescale 1ns/100ps

// Decoded keys, one-cycle pulses with their payload
interface key_if;
	logic              dir_valid;
	snake_pkg::dir_t   dir;
	logic              level_valid;
	snake_pkg::speed_t speed;

	modport source (
		output dir_valid, dir, level_valid, speed
	);
	modport sink (
		input dir_valid, dir, level_valid, speed
	);
endinterface

// Controller to engine, with game_over running back
interface step_if;
	logic init;
	logic running;
	logic step;
	logic game_over;

	modport source (
		output init, running, step,
		input  game_over
	);
	modport sink (
		input  init, running, step,
		output game_over
	);
endinterface

// File: snake_pkg.sv
// Shared grid sizes, key codes, register map and types of the Snake game logic
package snake_pkg;

	// ############################################################
	// Playfield and snake
	// ############################################################
	localparam int GRID_W       = 40;
	localparam int GRID_H       = 30;
	localparam int MAX_LEN      = 16;
	localparam int SELF_HIT_MIN = 4;
	localparam int STEP_CYCLES  = 16;

	typedef logic [5:0]  coord_t;
	typedef logic [4:0]  len_t;
	typedef logic [12:0] score_t;
	typedef logic [1:0]  dir_t;
	typedef logic [2:0]  speed_t;
	// Wide enough for the slowest speed times STEP_CYCLES
	typedef logic [6:0]  step_cnt_t;

	localparam dir_t DIR_UP    = 2'd0;
	localparam dir_t DIR_LEFT  = 2'd1;
	localparam dir_t DIR_DOWN  = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	localparam coord_t HEAD_X0  = 6'd5;
	localparam coord_t HEAD_Y0  = 6'd5;
	localparam coord_t APPLE_X0 = 6'd8;
	localparam coord_t APPLE_Y0 = 6'd5;

	// ############################################################
	// PS/2 scan codes and speeds
	// ############################################################
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1E;
	localparam logic [7:0] KEY_3     = 8'h26;
	localparam logic [7:0] KEY_BREAK = 8'hF0;

	localparam speed_t SPEED_1 = 3'd4;
	localparam speed_t SPEED_2 = 3'd2;
	localparam speed_t SPEED_3 = 3'd1;

	// APB byte addresses
	localparam logic [3:0] REG_STATUS = 4'h0;
	localparam logic [3:0] REG_SCORE  = 4'h4;
	localparam logic [3:0] REG_HEAD   = 4'h8;
	localparam logic [3:0] REG_APPLE  = 4'hC;

	typedef enum logic [2:0] {
		MENU,
		GAME_INIT,
		GAME_WAIT,
		PLAYING,
		GAME_OVER
	} game_state_t;

endpackage
